//--- common/event_log_params.svh
`ifndef EVENT_LOG_PARAMS_SVH
`define EVENT_LOG_PARAMS_SVH

// Entries held by the clock-crossing FIFO, power of two.
`define EL_FIFO_DEPTH 16

`define EL_PAYLOAD_W 16 // Event payload bits.

`define EL_DROP_W 16 // Marker drop count bits, same as payload.

`endif

//--- common/event_entry_pkg.sv
`include "event_log_params.svh"

package event_entry_pkg;

    typedef enum logic {
        KIND_DATA   = 1'b0, // Carries an event payload.
        KIND_MARKER = 1'b1  // Carries a drop count.
    } entry_kind_t;

    typedef struct packed {
        entry_kind_t               kind;    // Top bit, shared by both views.
        logic [`EL_PAYLOAD_W-1:0] payload; // Event word.
    } data_view_t;

    typedef struct packed {
        entry_kind_t            kind;       // Top bit, shared by both views.
        logic [`EL_DROP_W-1:0] drop_count; // Events lost while full.
    } marker_view_t;

    // One FIFO word, decoded by its kind bit.
    typedef union packed {
        data_view_t   data;   // Kind is KIND_DATA.
        marker_view_t marker; // Kind is KIND_MARKER.
    } event_entry_u;

    localparam int ENTRY_W = $bits(event_entry_u); // FIFO word width.

endpackage : event_entry_pkg

//--- common/event_reg_pkg.sv
`include "event_log_params.svh"

package event_reg_pkg;

    typedef enum logic [1:0] {
        REG_CTRL        = 2'd0, // Bit 0 enables delivery.
        REG_DATA_COUNT  = 2'd1, // Delivered events, write clears.
        REG_LOST_TOTAL  = 2'd2, // Sum of marker counts, write clears.
        REG_STATUS      = 2'd3  // Bit 0 mirrors FIFO empty.
    } reg_addr_t;

    typedef struct packed {
        logic enable; // Reader may pop entries.
    } log_ctrl_t;

    // Per-cycle results of the unpacker.
    typedef struct packed {
        logic                   data_strobe; // Data entry delivered.
        logic                   lost_strobe; // Marker entry decoded.
        logic [`EL_DROP_W-1:0] lost_count;  // Count from the marker.
    } unpack_stat_t;

endpackage : event_reg_pkg

//--- fifo/async_fifo.sv
`timescale 1ns/10ps

module async_fifo #(
    parameter int BUFFER_DEPTH = 16, // Entries, power of two.
    parameter int DATA_WIDTH   = 17  // Bits per entry.
) (
    input  logic                  write_clk_i,
    input  logic                  write_rstn_i,
    input  logic                  read_clk_i,
    input  logic                  read_rstn_i,
    input  logic                  write_i,
    input  logic                  read_i,
    input  logic [DATA_WIDTH-1:0] write_data_i,
    output logic [DATA_WIDTH-1:0] read_data_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH); // Address bits.

    logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH]; // Storage, no reset.

    logic [PTR_W:0] write_ptr; // Extra bit marks wraparound.
    logic [PTR_W:0] read_ptr;
    logic [PTR_W:0] write_gray;
    logic [PTR_W:0] read_gray;

    logic [1:0][PTR_W:0] write_gray_sync; // Write pointer in read domain.
    logic [1:0][PTR_W:0] read_gray_sync;  // Read pointer in write domain.

    always_ff @(posedge write_clk_i) begin
        if (write_i) begin
            mem[write_ptr[PTR_W-1:0]] <= write_data_i; // Full is checked upstream.
        end
    end

    always_ff @(posedge read_clk_i) begin
        if (read_i) begin
            read_data_o <= mem[read_ptr[PTR_W-1:0]]; // Valid one clock later.
        end
    end

    always_ff @(posedge write_clk_i) begin
        if (!write_rstn_i) begin
            write_ptr <= '0;
        end else if (write_i) begin
            write_ptr <= write_ptr + 1'b1;
        end
    end

    always_ff @(posedge read_clk_i) begin
        if (!read_rstn_i) begin
            read_ptr <= '0;
        end else if (read_i) begin
            read_ptr <= read_ptr + 1'b1;
        end
    end

    assign write_gray = (write_ptr >> 1) ^ write_ptr; // Binary to Gray.
    assign read_gray  = (read_ptr >> 1) ^ read_ptr;

    // Gray of zero is zero, so empty holds and full drops right after reset.
    always_ff @(posedge read_clk_i) begin
        if (!read_rstn_i) begin
            write_gray_sync <= '0;
        end else begin
            write_gray_sync <= {write_gray_sync[0], write_gray}; // Two flops.
        end
    end

    always_ff @(posedge write_clk_i) begin
        if (!write_rstn_i) begin
            read_gray_sync <= '0;
        end else begin
            read_gray_sync <= {read_gray_sync[0], read_gray}; // Two flops.
        end
    end

    // Full when the top two Gray bits differ and the rest match.
    assign full_o = (write_gray == {~read_gray_sync[1][PTR_W:PTR_W-1],
                                    read_gray_sync[1][PTR_W-2:0]});

    assign empty_o = (read_gray == write_gray_sync[1]); // Pointers equal.

endmodule : async_fifo

//--- hdl/event_packer.sv
`timescale 1ns/10ps
`include "event_log_params.svh"

module event_packer (
    input  logic                         write_clk_i,
    input  logic                         write_rstn_i,
    input  logic                         event_valid_i,
    input  logic [`EL_PAYLOAD_W-1:0]    event_data_i,
    input  logic                         fifo_full_i,
    output logic                         fifo_write_o,
    output event_entry_pkg::event_entry_u fifo_entry_o
);

    import event_entry_pkg::*;

    logic [`EL_DROP_W-1:0] drop_cnt; // Events lost since last marker.
    logic                  marker_due; // Space is back, count pending.
    logic                  drop_now;   // Event arrives with no space.

    assign marker_due = !fifo_full_i && (drop_cnt != '0);
    assign drop_now   = event_valid_i && fifo_full_i;

    // Marker wins the slot, a concurrent event is dropped.
    assign fifo_write_o = marker_due || (event_valid_i && !fifo_full_i);

    always_comb begin
        fifo_entry_o = '0;
        if (marker_due) begin
            fifo_entry_o.marker.kind       = KIND_MARKER;
            fifo_entry_o.marker.drop_count = drop_cnt; // Pending loss.
        end else begin
            fifo_entry_o.data.kind    = KIND_DATA;
            fifo_entry_o.data.payload = event_data_i; // Straight through.
        end
    end

    always_ff @(posedge write_clk_i) begin
        if (!write_rstn_i) begin
            drop_cnt <= '0;
        end else if (marker_due) begin
            drop_cnt <= {{(`EL_DROP_W-1){1'b0}}, event_valid_i}; // Restart at 1 or 0.
        end else if (drop_now && (drop_cnt != '1)) begin
            drop_cnt <= drop_cnt + 1'b1; // Saturates at all ones.
        end
    end

endmodule : event_packer

//--- hdl/event_unpacker.sv
`timescale 1ns/10ps
`include "event_log_params.svh"

module event_unpacker (
    input  logic                          read_clk_i,
    input  logic                          read_rstn_i,
    input  event_reg_pkg::log_ctrl_t      ctrl_i,
    input  logic                          fifo_empty_i,
    input  event_entry_pkg::event_entry_u fifo_entry_i,
    output logic                          fifo_read_o,
    output logic                          event_valid_o,
    output logic [`EL_PAYLOAD_W-1:0]     event_data_o,
    output event_reg_pkg::unpack_stat_t   stat_o
);

    import event_entry_pkg::*;

    logic read_pending; // Entry lands on fifo_entry_i this cycle.
    logic is_data;      // Kind bit says data.

    assign fifo_read_o = ctrl_i.enable && !fifo_empty_i; // Pop while allowed.

    always_ff @(posedge read_clk_i) begin
        if (!read_rstn_i) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= fifo_read_o; // One clock read latency.
        end
    end

    assign is_data = (fifo_entry_i.data.kind == KIND_DATA);

    assign event_valid_o = read_pending && is_data; // Markers never leave here.
    assign event_data_o  = fifo_entry_i.data.payload;

    assign stat_o.data_strobe = read_pending && is_data;
    assign stat_o.lost_strobe = read_pending && !is_data; // Marker view.
    assign stat_o.lost_count  = fifo_entry_i.marker.drop_count;

endmodule : event_unpacker

//--- hdl/log_regs.sv
`timescale 1ns/10ps

module log_regs (
    input  logic                        read_clk_i,
    input  logic                        read_rstn_i,
    input  logic                        reg_write_i,
    input  event_reg_pkg::reg_addr_t    reg_addr_i,
    input  logic [15:0]                 reg_wdata_i,
    output logic [15:0]                 reg_rdata_o,
    input  event_reg_pkg::unpack_stat_t stat_i,
    input  logic                        fifo_empty_i,
    output event_reg_pkg::log_ctrl_t    ctrl_o
);

    import event_reg_pkg::*;

    logic [15:0] data_count; // Delivered events.
    logic [15:0] lost_total; // Sum of marker counts.
    logic [16:0] lost_sum;   // Carry shows overflow.

    assign lost_sum = {1'b0, lost_total} + {1'b0, stat_i.lost_count};

    always_ff @(posedge read_clk_i) begin
        if (!read_rstn_i) begin
            ctrl_o <= '0; // Delivery off.
        end else if (reg_write_i && (reg_addr_i == REG_CTRL)) begin
            ctrl_o.enable <= reg_wdata_i[0];
        end
    end

    always_ff @(posedge read_clk_i) begin
        if (!read_rstn_i) begin
            data_count <= '0;
        end else if (reg_write_i && (reg_addr_i == REG_DATA_COUNT)) begin
            data_count <= '0; // Any value clears.
        end else if (stat_i.data_strobe && (data_count != '1)) begin
            data_count <= data_count + 1'b1; // Holds at max.
        end
    end

    always_ff @(posedge read_clk_i) begin
        if (!read_rstn_i) begin
            lost_total <= '0;
        end else if (reg_write_i && (reg_addr_i == REG_LOST_TOTAL)) begin
            lost_total <= '0;
        end else if (stat_i.lost_strobe) begin
            lost_total <= lost_sum[16] ? '1 : lost_sum[15:0]; // Clamp on carry.
        end
    end

    always_comb begin
        case (reg_addr_i)
            REG_CTRL:       reg_rdata_o = {15'd0, ctrl_o.enable};
            REG_DATA_COUNT: reg_rdata_o = data_count;
            REG_LOST_TOTAL: reg_rdata_o = lost_total;
            default:        reg_rdata_o = {15'd0, fifo_empty_i}; // Status.
        endcase
    end

endmodule : log_regs

//--- hdl/event_log_top.sv
`timescale 1ns/10ps
`include "event_log_params.svh"

module event_log_top (
    input  logic                     write_clk_i,
    input  logic                     write_rstn_i,
    input  logic                     read_clk_i,
    input  logic                     read_rstn_i,
    input  logic                     event_valid_i,
    input  logic [`EL_PAYLOAD_W-1:0] event_data_i,
    output logic                     event_valid_o,
    output logic [`EL_PAYLOAD_W-1:0] event_data_o,
    input  logic                     reg_write_i,
    input  event_reg_pkg::reg_addr_t reg_addr_i,
    input  logic [15:0]              reg_wdata_i,
    output logic [15:0]              reg_rdata_o
);

    import event_entry_pkg::*;
    import event_reg_pkg::*;

    logic         fifo_write; // Write domain.
    logic         fifo_full;
    event_entry_u write_entry;
    logic         fifo_read; // Read domain.
    logic         fifo_empty;
    event_entry_u read_entry;
    log_ctrl_t    ctrl;
    unpack_stat_t stat;

    event_packer u_event_packer (
        .write_clk_i   (write_clk_i),
        .write_rstn_i  (write_rstn_i),
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .fifo_full_i   (fifo_full),
        .fifo_write_o  (fifo_write),
        .fifo_entry_o  (write_entry)
    );

    async_fifo #(
        .BUFFER_DEPTH (`EL_FIFO_DEPTH),
        .DATA_WIDTH   (ENTRY_W) // One union word.
    ) u_async_fifo (
        .write_clk_i  (write_clk_i),
        .write_rstn_i (write_rstn_i),
        .read_clk_i   (read_clk_i),
        .read_rstn_i  (read_rstn_i),
        .write_i      (fifo_write),
        .read_i       (fifo_read),
        .write_data_i (write_entry),
        .read_data_o  (read_entry),
        .full_o       (fifo_full),
        .empty_o      (fifo_empty)
    );

    event_unpacker u_event_unpacker (
        .read_clk_i    (read_clk_i),
        .read_rstn_i   (read_rstn_i),
        .ctrl_i        (ctrl),
        .fifo_empty_i  (fifo_empty),
        .fifo_entry_i  (read_entry),
        .fifo_read_o   (fifo_read),
        .event_valid_o (event_valid_o),
        .event_data_o  (event_data_o),
        .stat_o        (stat)
    );

    log_regs u_log_regs (
        .read_clk_i   (read_clk_i),
        .read_rstn_i  (read_rstn_i),
        .reg_write_i  (reg_write_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .stat_i       (stat),
        .fifo_empty_i (fifo_empty),
        .ctrl_o       (ctrl)
    );

endmodule : event_log_top

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5, // Half of the clock period.
    parameter int RESET_CYCLES   = 3  // Edges seen with reset low.
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o; // Free running.
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1; // Released away from the sampling edge.
    end

endmodule : tb_clock_gen

//--- test/event_log_props.sv
`timescale 1ns/10ps

module event_log_props (
    input logic write_clk_i,
    input logic write_rstn_i,
    input logic read_clk_i,
    input logic read_rstn_i,
    input logic write_i,
    input logic read_i,
    input logic full_o,
    input logic empty_o
);

    // Only the packer guards full, so an overflow shows up here.
    no_write_when_full : assert property (@(posedge write_clk_i) disable iff (!write_rstn_i)
        !(write_i && full_o)) else $error("FIFO written while full");

    no_read_when_empty : assert property (@(posedge read_clk_i) disable iff (!read_rstn_i)
        !(read_i && empty_o)) else $error("FIFO read while empty");

    // From the second reset edge on, the pointers and counters are settled.
    write_quiet_in_reset : assert property (@(posedge write_clk_i)
        (!write_rstn_i && $past(!write_rstn_i)) |-> !write_i)
        else $error("FIFO write strobe high during write reset");

    read_quiet_in_reset : assert property (@(posedge read_clk_i)
        (!read_rstn_i && $past(!read_rstn_i)) |-> !read_i)
        else $error("FIFO read strobe high during read reset");

endmodule : event_log_props

bind async_fifo event_log_props u_event_log_props (.*);

//--- test/event_log_tb.sv
`timescale 1ns/10ps
`include "event_log_params.svh"

module event_log_tb;

    import event_reg_pkg::*;

    localparam int TIMEOUT_POLLS = 1000; // Register polls per wait.
    localparam int SETTLE_POLLS  = 8;    // Quiet polls that mean drained.
    localparam int NUM_PHASES    = 4;

    typedef struct packed {
        logic [7:0]  events;    // Events in the burst.
        logic [3:0]  spacing;   // Write clocks between event starts.
        logic        reader_on; // Delivery enabled during the burst.
        logic        clear;     // Counters cleared before the burst.
        logic [15:0] exp_data;  // DATA_COUNT after the phase.
        logic [15:0] exp_lost;  // LOST_TOTAL after the phase.
    } phase_t;

    logic                     write_clk, write_rstn, read_clk, read_rstn;
    logic                     event_valid, event_valid_out, reg_write;
    logic [`EL_PAYLOAD_W-1:0] event_data, event_data_out;
    reg_addr_t                reg_addr;
    logic [15:0]              reg_wdata, reg_rdata;

    phase_t                   phases [NUM_PHASES];
    logic [`EL_PAYLOAD_W-1:0] expected_q [$]; // Payloads still owed.
    logic [31:0]              lcg_state;
    logic                     delivery_on; // Events may appear.
    int                       checks, value_errors, other_errors, delivered;

    tb_clock_gen #(.HALF_PERIOD_NS(7)) u_write_clock (.clk_o(write_clk), .rstn_o(write_rstn));
    tb_clock_gen #(.HALF_PERIOD_NS(5)) u_read_clock (.clk_o(read_clk), .rstn_o(read_rstn));

    event_log_top u_event_log_top (
        .write_clk_i   (write_clk),
        .write_rstn_i  (write_rstn),
        .read_clk_i    (read_clk),
        .read_rstn_i   (read_rstn),
        .event_valid_i (event_valid),
        .event_data_i  (event_data),
        .event_valid_o (event_valid_out),
        .event_data_o  (event_data_out),
        .reg_write_i   (reg_write),
        .reg_addr_i    (reg_addr),
        .reg_wdata_i   (reg_wdata),
        .reg_rdata_o   (reg_rdata)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG.
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
        @(negedge read_clk);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge read_clk);
        reg_write = 1'b0; // Took effect on the edge between.
    endtask

    task automatic read_reg(input reg_addr_t addr, output logic [15:0] data);
        @(negedge read_clk);
        reg_addr = addr;
        @(negedge read_clk);
        data = reg_rdata; // Stable mid cycle.
    endtask

    task automatic expect_reg(input string name, input reg_addr_t addr,
                              input logic [15:0] expected);
        logic [15:0] value;
        read_reg(addr, value);
        check_value(name, {16'd0, value}, {16'd0, expected});
    endtask

    // Writes the burst and records which payloads the FIFO can hold.
    task automatic send_burst(input phase_t row);
        int stored;
        stored = 0;
        for (int i = 0; i < int'(row.events); i++) begin
            @(negedge write_clk);
            lcg_state   = lcg_step(lcg_state);
            event_valid = 1'b1;
            event_data  = lcg_state[31:16]; // Upper bits are more random.
            if (row.reader_on || stored < `EL_FIFO_DEPTH) begin
                expected_q.push_back(lcg_state[31:16]);
                stored++;
            end
            for (int g = 1; g < int'(row.spacing); g++) begin
                @(negedge write_clk);
                event_valid = 1'b0;
            end
        end
        @(negedge write_clk);
        event_valid = 1'b0;
    endtask

    task automatic wait_drained(input int phase);
        logic [15:0] status;
        int          quiet;
        int          polls;
        quiet = 0;
        polls = 0;
        while (quiet < SETTLE_POLLS && polls < TIMEOUT_POLLS) begin
            read_reg(REG_STATUS, status);
            quiet = (status[0] && expected_q.size() == 0) ? quiet + 1 : 0;
            polls++;
        end
        if (quiet < SETTLE_POLLS) begin
            other_errors++;
            $display("Timed out at %0t waiting for phase %0d to drain", $time, phase);
        end
    endtask

    task automatic wait_reset_done;
        int cycles;
        cycles = 0;
        while (!(read_rstn && write_rstn) && cycles < 100) begin
            @(negedge read_clk);
            cycles++;
        end
        if (!(read_rstn && write_rstn)) begin
            other_errors++;
            $display("Timed out at %0t waiting for both resets to release", $time);
        end
    endtask

    // Every delivered event must be the oldest payload still owed.
    always @(negedge read_clk) begin
        if (read_rstn && event_valid_out) begin
            if (!delivery_on) begin
                other_errors++;
                $display("Event delivered at %0t while the reader was disabled", $time);
            end
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("Event delivered at %0t with no payload left to match", $time);
            end else begin
                check_value("event_data_o", {16'd0, event_data_out},
                            {16'd0, expected_q.pop_front()});
                delivered++;
            end
        end
    end

    initial begin
        phase_t row;
        $timeformat(-9, 1, " ns", 10);
        phases[0] = '{8'd20, 4'd2, 1'b1, 1'b0, 16'd20, 16'd0}; // Steady flow.
        phases[1] = '{8'd25, 4'd1, 1'b0, 1'b0, 16'd36, 16'd9}; // Overflow by 9.
        phases[2] = '{8'd12, 4'd1, 1'b1, 1'b0, 16'd48, 16'd9}; // Resumes after marker.
        phases[3] = '{8'd8, 4'd1, 1'b0, 1'b1, 16'd8, 16'd0};   // Held, then released.
        event_valid  = 1'b0;
        event_data   = '0;
        reg_write    = 1'b0;
        reg_addr     = REG_CTRL;
        reg_wdata    = '0;
        lcg_state    = 32'h8f6d;
        delivery_on  = 1'b0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        delivered    = 0;
        wait_reset_done();
        expect_reg("CTRL", REG_CTRL, 16'd0);
        expect_reg("DATA_COUNT", REG_DATA_COUNT, 16'd0);
        expect_reg("LOST_TOTAL", REG_LOST_TOTAL, 16'd0);
        expect_reg("STATUS", REG_STATUS, 16'd1);
        for (int p = 0; p < NUM_PHASES; p++) begin
            row = phases[p];
            if (row.clear) begin
                write_reg(REG_DATA_COUNT, 16'hffff); // Any value clears.
                write_reg(REG_LOST_TOTAL, 16'hffff);
                delivered = 0;
                expect_reg("DATA_COUNT", REG_DATA_COUNT, 16'd0);
                expect_reg("LOST_TOTAL", REG_LOST_TOTAL, 16'd0);
            end
            if (row.reader_on) begin
                delivery_on = 1'b1;
                write_reg(REG_CTRL, 16'd1);
            end else begin
                write_reg(REG_CTRL, 16'd0);
                delivery_on = 1'b0; // FIFO already drained, nothing in flight.
                expect_reg("CTRL", REG_CTRL, 16'd0);
            end
            send_burst(row);
            if (!row.reader_on) begin
                repeat (20) @(negedge read_clk); // Well past the synchronizer delay.
                expect_reg("STATUS", REG_STATUS, 16'd0);
                delivery_on = 1'b1;
                write_reg(REG_CTRL, 16'd1);
            end
            wait_drained(p);
            check_value("delivered events", 32'(delivered), {16'd0, row.exp_data});
            expect_reg("DATA_COUNT", REG_DATA_COUNT, row.exp_data);
            expect_reg("LOST_TOTAL", REG_LOST_TOTAL, row.exp_lost);
            expect_reg("STATUS", REG_STATUS, 16'd1);
        end
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : event_log_tb

//--- files.f
+incdir+common
common/event_entry_pkg.sv
common/event_reg_pkg.sv
fifo/async_fifo.sv
hdl/event_packer.sv
hdl/event_unpacker.sv
hdl/log_regs.sv
hdl/event_log_top.sv
test/tb_clock_gen.sv
test/event_log_props.sv
test/event_log_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the event logger testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module event_log_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vevent_log_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
